// ==== hw/dma_settings.svh ====
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// width of one weight word
`define DMA_DATA_W 16

// 1024 ITCM words
`define ITCM_ADDR_W 10

// 256 words per weight buffer
`define BUF_ADDR_W 8

// bank 0 is conv, banks 1 to 4 are fc
`define NUM_BANKS 5

`endif

// ==== hw/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    `include "dma_settings.svh"

    // region lengths, sampled on start
    typedef struct packed {
        logic [`BUF_ADDR_W:0]    conv_len;
        logic [`BUF_ADDR_W:0]    fc_len;
    } dma_cfg_t;

    // itcm load port
    typedef struct packed {
        logic                    en;
        logic [`ITCM_ADDR_W-1:0] addr;
        logic [`DMA_DATA_W-1:0]  data;
    } itcm_wr_t;

    // one-hot bank write channel
    typedef struct packed {
        logic [`NUM_BANKS-1:0]   bank_en;
        logic [`BUF_ADDR_W-1:0]  addr;
        logic [`DMA_DATA_W-1:0]  data;
    } wb_wr_t;

    typedef struct packed {
        logic                    en;
        logic [2:0]              bank;
        logic [`BUF_ADDR_W-1:0]  addr;
    } wb_rd_t;

endpackage

`default_nettype wire

// ==== hw/itcm_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

module itcm_mem import dma_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  itcm_wr_t                i_wr,
    input  logic [`ITCM_ADDR_W-1:0] i_rd_addr,
    output logic [`DMA_DATA_W-1:0]  o_rd_data
);

    localparam int DEPTH = 1 << `ITCM_ADDR_W;

    logic [`DMA_DATA_W-1:0] mem [DEPTH];

    // load port
    always_ff @(posedge i_clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // read every cycle, one cycle latency
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_rd_data <= '0;
        end else begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/weight_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

module weight_dma import dma_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  dma_cfg_t                i_cfg,
    output logic [`ITCM_ADDR_W-1:0] o_itcm_addr,
    input  logic [`DMA_DATA_W-1:0]  i_itcm_data,
    output wb_wr_t                  o_wr,
    output logic                    o_busy,
    output logic                    o_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CONV,
        S_FC0,
        S_FC1,
        S_FC2,
        S_FC3
    } state_t;

    state_t                  state;
    state_t                  next_region;
    logic [`NUM_BANKS-1:0]   region_oh;
    logic [`BUF_ADDR_W-1:0]  word_cnt;
    logic [`ITCM_ADDR_W-1:0] itcm_addr;
    dma_cfg_t                cfg_q;
    logic [`BUF_ADDR_W:0]    region_len;
    logic                    region_last;
    logic                    accept;
    logic                    s1_valid;
    logic [`NUM_BANKS-1:0]   s1_mask;
    logic [`BUF_ADDR_W-1:0]  s1_addr;
    logic [`NUM_BANKS-1:0]   wr_en_q;
    logic [`BUF_ADDR_W-1:0]  wr_addr_q;
    logic [`DMA_DATA_W-1:0]  wr_data_q;
    logic                    drain_last;

    // start is ignored while a run is in flight
    assign accept = i_start && !o_busy;

    assign region_len  = (state == S_CONV) ? cfg_q.conv_len : cfg_q.fc_len;
    assign region_last = ({1'b0, word_cnt} == region_len - 1'b1);

    // last word sits in the write stage, nothing behind it
    assign drain_last = (|wr_en_q) && !s1_valid;

    always_comb begin
        case (state)
            S_CONV:  next_region = S_FC0;
            S_FC0:   next_region = S_FC1;
            S_FC1:   next_region = S_FC2;
            S_FC2:   next_region = S_FC3;
            default: next_region = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            region_oh <= '0;
            s1_valid  <= 1'b0;
            wr_en_q   <= '0;
            o_busy    <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            if (accept) begin
                state     <= S_CONV;
                region_oh <= `NUM_BANKS'(1);
            end else if (state != S_IDLE && region_last) begin
                // walk to the next buffer
                state     <= next_region;
                region_oh <= region_oh << 1;
            end

            if (accept) begin
                o_busy <= 1'b1;
            end else if (drain_last) begin
                o_busy <= 1'b0;
            end
            o_done <= drain_last;

            s1_valid <= (state != S_IDLE);
            wr_en_q  <= s1_valid ? s1_mask : '0;
        end
    end

    // address counters and data pipeline
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cfg_q     <= i_cfg;
            itcm_addr <= '0;
            word_cnt  <= '0;
        end else if (state != S_IDLE) begin
            itcm_addr <= itcm_addr + 1'b1;
            word_cnt  <= region_last ? '0 : word_cnt + 1'b1;
        end

        s1_mask   <= region_oh;
        s1_addr   <= word_cnt;
        wr_addr_q <= s1_addr;
        wr_data_q <= i_itcm_data;
    end

    assign o_itcm_addr = itcm_addr;

    assign o_wr.bank_en = wr_en_q;
    assign o_wr.addr    = wr_addr_q;
    assign o_wr.data    = wr_data_q;

endmodule

`default_nettype wire

// ==== hw/weight_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

module weight_bank import dma_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  wb_wr_t                 i_wr,
    input  wb_rd_t                 i_rd,
    output logic [`DMA_DATA_W-1:0] o_rd_data
);

    localparam int DEPTH = 1 << `BUF_ADDR_W;

    logic [`DMA_DATA_W-1:0] mem [`NUM_BANKS][DEPTH];
    logic                   rd_bank_ok;

    // indexes 5 to 7 do not exist
    assign rd_bank_ok = (i_rd.bank < 3'(`NUM_BANKS));

    // shared write channel, one enable per buffer
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (i_wr.bank_en[b]) begin
                mem[b][i_wr.addr] <= i_wr.data;
            end
        end
    end

    // registered readout, holds until the next read
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd.en) begin
            if (rd_bank_ok) begin
                o_rd_data <= mem[i_rd.bank][i_rd.addr];
            end else begin
                o_rd_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/weight_load_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

module weight_load_top import dma_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  dma_cfg_t               i_cfg,
    input  itcm_wr_t               i_itcm_wr,
    input  wb_rd_t                 i_rd,
    output logic [`DMA_DATA_W-1:0] o_rd_data,
    output logic                   o_busy,
    output logic                   o_done
);

    logic [`ITCM_ADDR_W-1:0] itcm_rd_addr;
    logic [`DMA_DATA_W-1:0]  itcm_rd_data;
    wb_wr_t                  wb_wr;

    itcm_mem u_itcm (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (i_itcm_wr),
        .i_rd_addr (itcm_rd_addr),
        .o_rd_data (itcm_rd_data)
    );

    weight_dma u_dma (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_cfg       (i_cfg),
        .o_itcm_addr (itcm_rd_addr),
        .i_itcm_data (itcm_rd_data),
        .o_wr        (wb_wr),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    weight_bank u_bank (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (wb_wr),
        .i_rd      (i_rd),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

// ==== sim/tb_weight_load.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

module tb_weight_load import dma_pkg::*;;

    localparam int RUN1_CONV = 20;
    localparam int RUN1_FC   = 12;
    localparam int RUN1_N    = RUN1_CONV + 4 * RUN1_FC;
    localparam int RUN2_CONV = 7;
    localparam int RUN2_FC   = 30;
    localparam int RUN2_N    = RUN2_CONV + 4 * RUN2_FC;
    // config carried by the ignored start
    localparam int POKE_CONV = 5;
    localparam int POKE_FC   = 40;
    // three runs in total
    localparam int TIMEOUT   = 4 * ((RUN1_N + RUN1_N + RUN2_N) + 300);
    localparam int BUF_DEPTH = 1 << `BUF_ADDR_W;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_start;
    dma_cfg_t               i_cfg;
    itcm_wr_t               i_itcm_wr;
    wb_rd_t                 i_rd;
    logic [`DMA_DATA_W-1:0] o_rd_data;
    logic                   o_busy;
    logic                   o_done;

    logic [`DMA_DATA_W-1:0] itcm_img [1 << `ITCM_ADDR_W];
    logic [`DMA_DATA_W-1:0] exp_mem [`NUM_BANKS][BUF_DEPTH];
    bit                     exp_known [`NUM_BANKS][BUF_DEPTH];

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;
    string  test_name;

    // timing model state
    bit     tracking = 1'b0;
    int     run_cyc = 0;
    int     run_n = 0;
    int     done_pulses = 0;

    weight_load_top u_dut (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (i_start),
        .i_cfg     (i_cfg),
        .i_itcm_wr (i_itcm_wr),
        .i_rd      (i_rd),
        .o_rd_data (o_rd_data),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Fail %s: expected 0x%0h, actual 0x%0h", what, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    // expected buffer word from the region layout in the ITCM
    function automatic logic [`DMA_DATA_W-1:0] ref_word(input int bank, input int idx,
                                                       input int conv_len, input int fc_len);
        int addr;
        if (bank == 0) begin
            addr = idx;
        end else begin
            addr = conv_len + (bank - 1) * fc_len + idx;
        end
        return itcm_img[addr];
    endfunction

    task automatic load_itcm(input int n);
        logic [`DMA_DATA_W-1:0] word;
        for (int a = 0; a < n; a++) begin
            word = `DMA_DATA_W'($random(seed));
            @(negedge i_clk);
            i_itcm_wr.en   = 1'b1;
            i_itcm_wr.addr = `ITCM_ADDR_W'(a);
            i_itcm_wr.data = word;
            itcm_img[a]    = word;
        end
        @(negedge i_clk);
        i_itcm_wr.en = 1'b0;
    endtask

    task automatic update_expected(input int conv_len, input int fc_len);
        int len;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            len = (b == 0) ? conv_len : fc_len;
            for (int i = 0; i < len; i++) begin
                exp_mem[b][i]   = ref_word(b, i, conv_len, fc_len);
                exp_known[b][i] = 1'b1;
            end
        end
    endtask

    task automatic check_contents();
        logic [`DMA_DATA_W-1:0] got;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                if (exp_known[b][i]) begin
                    @(negedge i_clk);
                    i_rd.en   = 1'b1;
                    i_rd.bank = 3'(b);
                    i_rd.addr = `BUF_ADDR_W'(i);
                    @(negedge i_clk);
                    i_rd.en = 1'b0;
                    got = o_rd_data;
                    checks++;
                    assert (got === exp_mem[b][i]) else
                        report_mismatch($sformatf("%s bank %0d word %0d", test_name, b, i),
                                        32'(exp_mem[b][i]), 32'(got));
                end
            end
        end
    endtask

    task automatic run_dma(input int conv_len, input int fc_len, input bit poke);
        @(negedge i_clk);
        i_cfg.conv_len = 9'(conv_len);
        i_cfg.fc_len   = 9'(fc_len);
        i_start        = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        if (poke) begin
            repeat ((conv_len + 4 * fc_len) / 2) @(negedge i_clk);
            i_cfg.conv_len = 9'(POKE_CONV);
            i_cfg.fc_len   = 9'(POKE_FC);
            i_start        = 1'b1;
            @(negedge i_clk);
            i_start = 1'b0;
        end
        while (!o_done) @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        @(posedge i_clk);
        checks++;
        assert (done_pulses == 1) else
            report_mismatch({test_name, " done pulse count"}, 32'd1, 32'(done_pulses));
    endtask

    // accepting edge and cycle count of the run in flight
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            tracking = 1'b0;
        end else begin
            // run is over once its done cycle has been checked
            if (tracking && run_cyc == run_n + 3) begin
                tracking = 1'b0;
            end
            if (tracking) begin
                run_cyc = run_cyc + 1;
            end else if (i_start) begin
                tracking = 1'b1;
                run_cyc  = 1;
                run_n    = int'(i_cfg.conv_len) + 4 * int'(i_cfg.fc_len);
            end
        end
    end

    // busy and done against the timing rule
    always @(negedge i_clk) begin
        logic exp_busy;
        logic exp_done;
        if (i_rst_n) begin
            if (tracking && run_cyc == 1) begin
                done_pulses = 0;
            end
            if (o_done) begin
                done_pulses++;
            end
            if (tracking) begin
                exp_busy = (run_cyc < run_n + 3);
                exp_done = (run_cyc == run_n + 3);
                checks += 2;
                assert (o_busy === exp_busy) else
                    report_mismatch($sformatf("%s busy in cycle %0d", test_name, run_cyc),
                                    32'(exp_busy), 32'(o_busy));
                assert (o_done === exp_done) else
                    report_mismatch($sformatf("%s done in cycle %0d", test_name, run_cyc),
                                    32'(exp_done), 32'(o_done));
            end else begin
                checks += 2;
                assert (o_busy === 1'b0) else
                    report_problem({test_name, ": o_busy is high with no run in progress"});
                assert (o_done === 1'b0) else
                    report_problem({test_name, ": o_done pulsed with no run in progress"});
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT) begin
            @(posedge i_clk);
            cycle_count++;
        end
        report_problem($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT));
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed      = 32'h5b5b_8df5;
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_cfg     = '0;
        i_itcm_wr = '0;
        i_rd      = '0;
        test_name = "reset";
        for (int b = 0; b < `NUM_BANKS; b++) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                exp_known[b][i] = 1'b0;
            end
        end
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        checks += 3;
        assert (o_busy === 1'b0) else report_mismatch("reset busy", 32'd0, 32'(o_busy));
        assert (o_done === 1'b0) else report_mismatch("reset done", 32'd0, 32'(o_done));
        assert (o_rd_data === '0) else
            report_mismatch("reset rd_data", 32'd0, 32'(o_rd_data));

        test_name = "run1";
        load_itcm(RUN1_N);
        run_dma(RUN1_CONV, RUN1_FC, 1'b0);
        update_expected(RUN1_CONV, RUN1_FC);
        check_contents();

        // same image again with an extra start mid-run
        test_name = "busy_start";
        run_dma(RUN1_CONV, RUN1_FC, 1'b1);
        check_contents();

        test_name = "run2";
        load_itcm(RUN2_N);
        run_dma(RUN2_CONV, RUN2_FC, 1'b0);
        update_expected(RUN2_CONV, RUN2_FC);
        check_contents();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/dma_pkg.sv
hw/itcm_mem.sv
hw/weight_dma.sv
hw/weight_bank.sv
hw/weight_load_top.sv
sim/tb_weight_load.sv

// ==== Bender.yml ====
package:
  name: weight_load

export_include_dirs:
  - hw

sources:
  - files:
      - hw/dma_pkg.sv
      - hw/itcm_mem.sv
      - hw/weight_dma.sv
      - hw/weight_bank.sv
      - hw/weight_load_top.sv

  - target: test
    files:
      - sim/tb_weight_load.sv
